//--- Bender.yml
package:
  name: rf_subsys

sources:
  - files:
      - common/rf_pkg.sv
      - rf/rf_icg.sv
      - rf/rf.sv
      - verilog/apb_rf_bridge.sv
      - verilog/rf_alu_lane.sv
      - verilog/rf_subsys_top.sv
  - target: test
    files:
      - testbench/rf_assert.sv
      - testbench/rf_subsys_checker.sv
      - testbench/tb_rf_subsys.sv

//--- all.f
common/rf_pkg.sv
rf/rf_icg.sv
rf/rf.sv
verilog/apb_rf_bridge.sv
verilog/rf_alu_lane.sv
verilog/rf_subsys_top.sv
testbench/rf_assert.sv
testbench/rf_subsys_checker.sv
testbench/tb_rf_subsys.sv

//--- common/rf_pkg.sv
// Register-file word count, address width, ALU opcode enum and ALU operation struct
package rf_pkg;

  // Number of register-file words
  // Fixed, since the operation struct carries word addresses
  localparam int RF_N = 16;

  // Word address width
  localparam int RF_AW = $clog2(RF_N);

  // ALU opcode, 2 bits
  typedef enum logic [1:0] {
    // rd = rs1 + rs2
    OPC_ADD = 2'd0,
    // rd = rs1 - rs2
    OPC_SUB = 2'd1,
    // rd = rs1 & rs2
    OPC_AND = 2'd2,
    // rd = rs1 ^ rs2
    OPC_XOR = 2'd3
  } rf_opc_e;

  // One ALU operation, 14 bits
  // Opcode in the top bits, then destination and both sources
  typedef struct packed {
    // Operation to perform
    rf_opc_e          opc;
    // Destination word
    logic [RF_AW-1:0] rd;
    // First source word
    logic [RF_AW-1:0] rs1;
    // Second source word
    logic [RF_AW-1:0] rs2;
  } rf_op_t;

endpackage : rf_pkg

//--- rf/rf.sv
// Multi-port register file with write decode, port priority, per-word clock gating and read muxes
`timescale 1ns/1ps

module rf #(
  // Word width in bits
  parameter int W    = 32
  // Read port count
, parameter int RD_N = 1
  // Write port count
, parameter int WR_N = 1
) (
  input  wire logic                               clk
  // Read ports, address to data with no register
, input  wire logic [RD_N-1:0][rf_pkg::RF_AW-1:0] i_ra
, output wire logic [RD_N-1:0][W-1:0]             o_rdata
  // Write ports, highest-numbered port wins a collision
, input  wire logic [WR_N-1:0]                    i_wen
, input  wire logic [WR_N-1:0][rf_pkg::RF_AW-1:0] i_wa
, input  wire logic [WR_N-1:0][W-1:0]             i_wdata
);

  localparam int N  = rf_pkg::RF_N;
  localparam int AW = rf_pkg::RF_AW;

  // One-hot write address per port
  logic [WR_N-1:0][N-1:0] wa_dec;
  // Ports hitting each word
  logic [N-1:0][WR_N-1:0] wr_port_sel;
  // Port actually stored into each word, at most one bit set
  logic [N-1:0][WR_N-1:0] wr_port_win;
  // Word enable and next data
  logic [N-1:0]           word_en;
  logic [N-1:0][W-1:0]    word_w;
  // Gated clock and stored value per word
  logic [N-1:0]           word_clk;
  logic [N-1:0][W-1:0]    word_q;
  // One-hot read select and read data per port
  logic [RD_N-1:0][N-1:0] rd_sel;
  logic [RD_N-1:0][W-1:0] rdata;

  // Write address decoders
  for (genvar wr = 0; wr < WR_N; wr++) begin : g_wr_dec
    for (genvar n = 0; n < N; n++) begin : g_bit
      assign wa_dec[wr][n] = (i_wa[wr] == AW'(n));
    end : g_bit
  end : g_wr_dec

  for (genvar n = 0; n < N; n++) begin : g_word
    logic [WR_N-1:0] win;
    logic [W-1:0]    wdat;
    logic [W-1:0]    q;

    // Enabled ports addressing this word
    for (genvar wr = 0; wr < WR_N; wr++) begin : g_sel
      assign wr_port_sel[n][wr] = i_wen[wr] & wa_dec[wr][n];
    end : g_sel

    // Mask every port below the highest hitting one
    always_comb begin
      logic higher;
      higher = 1'b0;
      for (int wr = WR_N - 1; wr >= 0; wr--) begin
        win[wr] = wr_port_sel[n][wr] & ~higher;
        higher  = higher | wr_port_sel[n][wr];
      end
    end

    // One-hot write data mux
    always_comb begin
      wdat = '0;
      for (int wr = 0; wr < WR_N; wr++) begin
        wdat = wdat | ({W{win[wr]}} & i_wdata[wr]);
      end
    end

    assign wr_port_win[n] = win;
    assign word_w[n]      = wdat;
    assign word_en[n]     = |wr_port_sel[n];

    // Clock only ticks on cycles that write this word
    rf_icg u_icg (
      .i_clk       (clk)
    , .i_en        (word_en[n])
    , .o_clk_gated (word_clk[n])
    );

    // Storage word, no reset
    // Enable also keeps the word safe from an unknown gate at start-up
    always_ff @(posedge word_clk[n]) begin
      if (word_en[n]) begin
        q <= word_w[n];
      end
    end

    assign word_q[n] = q;
  end : g_word

  // Read ports
  for (genvar rd = 0; rd < RD_N; rd++) begin : g_rd
    logic [W-1:0] y;

    // Read address decoder
    for (genvar n = 0; n < N; n++) begin : g_bit
      assign rd_sel[rd][n] = (i_ra[rd] == AW'(n));
    end : g_bit

    // One-hot word select
    always_comb begin
      y = '0;
      for (int n = 0; n < N; n++) begin
        y = y | ({W{rd_sel[rd][n]}} & word_q[n]);
      end
    end

    assign rdata[rd] = y;
  end : g_rd

  assign o_rdata = rdata;

endmodule : rf

//--- rf/rf_icg.sv
// Latch-based integrated clock gate for one register-file storage word
`timescale 1ns/1ps

module rf_icg (
  // Free-running clock
  input  wire logic i_clk
  // Word enable, must settle while the clock is low
, input  wire logic i_en
  // Clock to the storage word
, output wire logic o_clk_gated
);

  // Test override, held off in this design
  logic dft_en;
  // Enable as captured during the low phase
  logic en_l;

  assign dft_en = 1'b0;

  // Transparent while the clock is low, so the enable
  // cannot change during the high phase and glitch the clock
  always_latch begin
    if (!i_clk) begin
      en_l <= i_en | dft_en;
    end
  end

  assign o_clk_gated = i_clk & en_l;

endmodule : rf_icg

//--- testbench/rf_assert.sv
// Concurrent assertions on register-file port priority, word hold and bridge write enable
`timescale 1ns/1ps

module rf_assert #(
  // Word width in bits
  parameter int W    = 32
  // Write port count of the register file
, parameter int WR_N = 2
) (
  input  wire logic                                    clk
, input  wire logic                                    i_rst_n
  // APB phase signals at the subsystem boundary
, input  wire logic                                    i_psel
, input  wire logic                                    i_penable
, input  wire logic                                    i_pwrite
, input  wire logic [rf_pkg::RF_AW+1:0]                i_paddr
  // Write port 0, driven by the bridge
, input  wire logic                                    i_bridge_wen
  // Register-file internals
, input  wire logic [rf_pkg::RF_N-1:0][WR_N-1:0]       i_port_win
, input  wire logic [rf_pkg::RF_N-1:0]                 i_word_en
, input  wire logic [rf_pkg::RF_N-1:0][W-1:0]          i_word_q
);

  // Failed assertions so far, read by the testbench top
  int unsigned fail_cnt = 0;

  for (genvar n = 0; n < rf_pkg::RF_N; n++) begin : g_word
    // At most one port is stored into a word
    a_one_port: assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(i_port_win[n]))
    else begin
      $error("word %0d stored from more than one write port", n);
      fail_cnt++;
    end

    // Word without enable keeps its value across the edge
    a_word_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_word_en[n] |=> (i_word_q[n] === $past(i_word_q[n])))
    else begin
      $error("word %0d changed without its write enable", n);
      fail_cnt++;
    end
  end : g_word

  // Bridge writes only in the access cycle of an in-range APB write after its setup cycle
  a_bridge_wen: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_bridge_wen |-> (i_psel && i_penable && i_pwrite && (i_paddr < rf_pkg::RF_N)
                      && $past(i_psel && !i_penable)))
  else begin
    $error("bridge write enable high outside an in-range APB write access");
    fail_cnt++;
  end

endmodule : rf_assert

bind rf_subsys_top rf_assert #(.W(W), .WR_N(WR_N)) u_assert (
  .clk          (clk)
, .i_rst_n      (i_rst_n)
, .i_psel       (i_psel)
, .i_penable    (i_penable)
, .i_pwrite     (i_pwrite)
, .i_paddr      (i_paddr)
, .i_bridge_wen (rf_wen[0])
, .i_port_win   (u_rf.wr_port_win)
, .i_word_en    (u_rf.word_en)
, .i_word_q     (u_rf.word_q)
);

//--- testbench/rf_subsys_checker.sv
// Monitor with word model and ALU reference, comparing APB reads, slave errors and ALU results
`timescale 1ns/1ps

module rf_subsys_checker #(
  // Data width in bits
  parameter int W = 32
) (
  input  wire logic                     clk
, input  wire logic                     i_rst_n
  // APB as seen at the DUT
, input  wire logic                     i_psel
, input  wire logic                     i_penable
, input  wire logic                     i_pwrite
, input  wire logic [rf_pkg::RF_AW+1:0] i_paddr
, input  wire logic [W-1:0]             i_pwdata
, input  wire logic [W-1:0]             i_prdata
, input  wire logic                     i_pready
, input  wire logic                     i_pslverr
  // ALU lane as seen at the DUT
, input  wire logic                     i_op_valid
, input  wire rf_pkg::rf_op_t           i_op
, input  wire logic                     i_res_valid
, input  wire logic [rf_pkg::RF_AW-1:0] i_res_rd
, input  wire logic [W-1:0]             i_res_data
  // Running totals
, output int                            o_errors
, output int                            o_checks
);

  localparam int AW = rf_pkg::RF_AW;

  // Model of the stored words
  logic [W-1:0]  mem [0:rf_pkg::RF_N-1];
  // Expected result waiting in the lane
  logic          pend_v;
  logic [AW-1:0] pend_rd;
  logic [W-1:0]  pend_data;
  logic [W-1:0]  opa;
  logic [W-1:0]  opb;
  logic [W-1:0]  new_data;
  logic          apb_acc;
  logic          oor;
  string         test_name = "reset";
  int            errors = 0;
  int            checks = 0;
  int            test_err_base = 0;
  int            n_tests = 0;
  int            n_failed = 0;

  assign o_errors = errors;
  assign o_checks = checks;

  // Opcode rule of the lane
  function automatic logic [W-1:0] alu_ref(input rf_pkg::rf_opc_e opc,
                                           input logic [W-1:0] a, input logic [W-1:0] b);
    case (opc)
      rf_pkg::OPC_ADD: return a + b;
      rf_pkg::OPC_SUB: return a - b;
      rf_pkg::OPC_AND: return a & b;
      default:         return a ^ b;
    endcase
  endfunction

  task automatic compare(input string what, input logic [W-1:0] exp, input logic [W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    n_tests++;
    if (errors == test_err_base) begin
      $display("Test %s passed", test_name);
    end else begin
      n_failed++;
      $display("Test %s failed with %0d errors", test_name, errors - test_err_base);
    end
  endtask

  // Sampled before this edge's register updates, so values are those of the ending cycle
  always @(posedge clk) begin
    if (!i_rst_n) begin
      pend_v = 1'b0;
    end else begin
      // Result of the op accepted one cycle earlier
      compare("res_valid", W'(pend_v), W'(i_res_valid));
      if (pend_v) begin
        compare("res_rd", W'(pend_rd), W'(i_res_rd));
        compare("res_data", pend_data, i_res_data);
      end
      // APB access cycle, no wait states
      apb_acc = i_psel && i_penable;
      oor     = (i_paddr >= rf_pkg::RF_N);
      compare("pready", W'(apb_acc), W'(i_pready));
      compare("pslverr", W'(apb_acc && oor), W'(i_pslverr));
      if (apb_acc && !i_pwrite) begin
        compare("prdata", oor ? '0 : mem[i_paddr[AW-1:0]], i_prdata);
      end
      // Operands from the model, pending result forwarded
      if (i_op_valid) begin
        opa      = (pend_v && pend_rd == i_op.rs1) ? pend_data : mem[i_op.rs1];
        opb      = (pend_v && pend_rd == i_op.rs2) ? pend_data : mem[i_op.rs2];
        new_data = alu_ref(i_op.opc, opa, opb);
      end
      // Writes at this edge, lane last so it wins
      if (apb_acc && i_pwrite && !oor) begin
        mem[i_paddr[AW-1:0]] = i_pwdata;
      end
      if (pend_v) begin
        mem[pend_rd] = pend_data;
      end
      pend_v    = i_op_valid;
      pend_rd   = i_op.rd;
      pend_data = new_data;
    end
  end

endmodule : rf_subsys_checker

//--- testbench/tb_rf_subsys.sv
// Testbench top with clock, reset, APB and ALU stimulus, watchdog and summary
`timescale 1ns/1ps

module tb_rf_subsys;

  localparam int W      = 32;
  localparam int AW     = rf_pkg::RF_AW;
  localparam int N      = rf_pkg::RF_N;
  localparam int CLK_NS = 4;
  // Transfers per test
  localparam int XFER_FILL  = 2 * N;
  localparam int XFER_RANGE = 3 + N;
  localparam int XFER_OPC   = 16;
  localparam int XFER_FWD   = 6;
  localparam int XFER_COLL  = 3;
  localparam int XFER_MIX   = 200;
  localparam int XFER_ALL   = XFER_FILL + XFER_RANGE + XFER_OPC + XFER_FWD + XFER_COLL + XFER_MIX;
  // Four cycles per transfer plus reset and drain margin
  localparam int TIMEOUT_NS = (XFER_ALL * 4 + 100) * CLK_NS;

  logic            clk;
  logic            rst_n;
  logic            psel;
  logic            penable;
  logic            pwrite;
  logic [AW+1:0]   paddr;
  logic [W-1:0]    pwdata;
  logic [W-1:0]    prdata;
  logic            pready;
  logic            pslverr;
  logic            op_valid;
  rf_pkg::rf_op_t  op_in;
  logic            res_valid;
  logic [AW-1:0]   res_rd;
  logic [W-1:0]    res_data;
  int              errors;
  int              checks;
  integer          seed;
  logic [31:0]     r;
  // Address picked for a random transfer
  logic [AW+1:0]   addr;
  rf_pkg::rf_op_t  op_a;
  rf_pkg::rf_op_t  op_b;
  rf_pkg::rf_op_t  op_c;

  rf_subsys_top #(.W(W)) u_dut (
    .clk         (clk)
  , .i_rst_n     (rst_n)
  , .i_psel      (psel)
  , .i_penable   (penable)
  , .i_pwrite    (pwrite)
  , .i_paddr     (paddr)
  , .i_pwdata    (pwdata)
  , .o_prdata    (prdata)
  , .o_pready    (pready)
  , .o_pslverr   (pslverr)
  , .i_op_valid  (op_valid)
  , .i_op        (op_in)
  , .o_res_valid (res_valid)
  , .o_res_rd    (res_rd)
  , .o_res_data  (res_data)
  );

  rf_subsys_checker #(.W(W)) u_chk (
    .clk         (clk)
  , .i_rst_n     (rst_n)
  , .i_psel      (psel)
  , .i_penable   (penable)
  , .i_pwrite    (pwrite)
  , .i_paddr     (paddr)
  , .i_pwdata    (pwdata)
  , .i_prdata    (prdata)
  , .i_pready    (pready)
  , .i_pslverr   (pslverr)
  , .i_op_valid  (op_valid)
  , .i_op        (op_in)
  , .i_res_valid (res_valid)
  , .i_res_rd    (res_rd)
  , .i_res_data  (res_data)
  , .o_errors    (errors)
  , .o_checks    (checks)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

  // One APB transfer, optionally issuing an op in its setup cycle
  task automatic apb_xfer(input logic wr, input logic [AW+1:0] addr, input logic [W-1:0] data,
                          input logic with_op, input rf_pkg::rf_op_t op);
    @(negedge clk);
    psel     = 1'b1;
    penable  = 1'b0;
    pwrite   = wr;
    paddr    = addr;
    pwdata   = data;
    op_valid = with_op;
    op_in    = op;
    @(negedge clk);
    penable  = 1'b1;
    op_valid = 1'b0;
    @(posedge clk);
    while (!pready) @(posedge clk);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Op valid for one cycle unless the next call keeps it going
  task automatic alu_issue(input rf_pkg::rf_op_t op);
    @(negedge clk);
    op_valid = 1'b1;
    op_in    = op;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      psel     = 1'b0;
      penable  = 1'b0;
      op_valid = 1'b0;
    end
  endtask

  task automatic make_op(input rf_pkg::rf_opc_e opc, output rf_pkg::rf_op_t op);
    logic [31:0] v;
    v      = $random(seed);
    op.opc = opc;
    op.rd  = v[AW-1:0];
    op.rs1 = v[2*AW-1:AW];
    op.rs2 = v[3*AW-1:2*AW];
  endtask

  initial begin
    seed     = 14715;
    rst_n    = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    op_valid = 1'b0;
    op_in    = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Every word written then read back
    u_chk.start_test("apb_fill");
    for (int i = 0; i < N; i++) begin
      r = $random(seed);
      apb_xfer(1'b1, (AW+2)'(i), r, 1'b0, '0);
    end
    for (int i = 0; i < N; i++) begin
      apb_xfer(1'b0, (AW+2)'(i), '0, 1'b0, '0);
    end
    u_chk.end_test();

    // Out-of-range accesses, then all words unchanged
    u_chk.start_test("apb_range");
    apb_xfer(1'b1, (AW+2)'(N), 32'h5a5a_0001, 1'b0, '0);
    apb_xfer(1'b1, '1, 32'h5a5a_0002, 1'b0, '0);
    apb_xfer(1'b0, (AW+2)'(N + 1), '0, 1'b0, '0);
    for (int i = 0; i < N; i++) begin
      apb_xfer(1'b0, (AW+2)'(i), '0, 1'b0, '0);
    end
    u_chk.end_test();

    // Each opcode twice, result read back over APB
    u_chk.start_test("alu_opcodes");
    for (int k = 0; k < 8; k++) begin
      make_op(rf_pkg::rf_opc_e'(k[2:1]), op_a);
      alu_issue(op_a);
      idle_cycles(1);
      apb_xfer(1'b0, {2'b00, op_a.rd}, '0, 1'b0, '0);
    end
    u_chk.end_test();

    // Dependent ops back to back
    // Second op takes rs1 from the first, third takes rs2 from the second
    u_chk.start_test("alu_forward");
    op_a = '{opc: rf_pkg::OPC_ADD, rd: 4'd3, rs1: 4'd1, rs2: 4'd2};
    op_b = '{opc: rf_pkg::OPC_XOR, rd: 4'd4, rs1: 4'd3, rs2: 4'd1};
    op_c = '{opc: rf_pkg::OPC_SUB, rd: 4'd5, rs1: 4'd3, rs2: 4'd4};
    alu_issue(op_a);
    alu_issue(op_b);
    alu_issue(op_c);
    idle_cycles(1);
    apb_xfer(1'b0, 6'd3, '0, 1'b0, '0);
    apb_xfer(1'b0, 6'd4, '0, 1'b0, '0);
    apb_xfer(1'b0, 6'd5, '0, 1'b0, '0);
    u_chk.end_test();

    // APB write and lane result hit word 7 at the same edge
    u_chk.start_test("write_collision");
    op_a = '{opc: rf_pkg::OPC_AND, rd: 4'd7, rs1: 4'd8, rs2: 4'd9};
    apb_xfer(1'b1, 6'd7, 32'hdead_beef, 1'b1, op_a);
    apb_xfer(1'b0, 6'd7, '0, 1'b0, '0);
    apb_xfer(1'b0, 6'd8, '0, 1'b0, '0);
    u_chk.end_test();

    // Random APB and ALU traffic
    u_chk.start_test("random_mix");
    for (int i = 0; i < XFER_MIX; i++) begin
      r = $random(seed);
      make_op(rf_pkg::rf_opc_e'(r[13:12]), op_a);
      // Mostly in range, one in eight above the word count
      addr = (r[7:5] == 3'd0) ? {r[9:8] | 2'b01, r[AW-1:0]} : {2'b00, r[AW-1:0]};
      case (r[1:0])
        2'd0, 2'd1: alu_issue(op_a);
        2'd2:       apb_xfer(1'b1, addr, $random(seed), r[2], op_a);
        default:    apb_xfer(1'b0, addr, '0, r[2], op_a);
      endcase
    end
    idle_cycles(2);
    u_chk.end_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             u_chk.n_tests, u_chk.n_failed, checks, errors, u_dut.u_assert.fail_cnt);
    if (errors == 0 && u_dut.u_assert.fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule : tb_rf_subsys

//--- verilog/apb_rf_bridge.sv
// APB slave giving word read and write access through one register-file read and write port
`timescale 1ns/1ps

module apb_rf_bridge #(
  // Data width in bits
  parameter int W = 32
) (
  input  wire logic                       clk
, input  wire logic                       i_rst_n
  // APB slave side
, input  wire logic                       i_psel
, input  wire logic                       i_penable
, input  wire logic                       i_pwrite
, input  wire logic [rf_pkg::RF_AW+1:0]   i_paddr
, input  wire logic [W-1:0]               i_pwdata
, output wire logic [W-1:0]               o_prdata
, output wire logic                       o_pready
, output wire logic                       o_pslverr
  // Register-file read port
, output wire logic [rf_pkg::RF_AW-1:0]   o_ra
, input  wire logic [W-1:0]               i_rdata
  // Register-file write port
, output wire logic                       o_wen
, output wire logic [rf_pkg::RF_AW-1:0]   o_wa
, output wire logic [W-1:0]               o_wdata
);

  localparam int AW = rf_pkg::RF_AW;

  // Transfer captured in the setup cycle
  typedef struct packed {
    logic          write;
    // Address at or above the word count
    logic          oor;
    logic [AW-1:0] addr;
    logic [W-1:0]  wdata;
  } apb_req_t;

  apb_req_t req_d;
  apb_req_t req_q;
  logic     setup;
  logic     acc_q;
  logic     access;

  // Setup cycle, select without enable
  assign setup = i_psel & ~i_penable;

  assign req_d.write = i_pwrite;
  assign req_d.oor   = |i_paddr[AW+1:AW];
  assign req_d.addr  = i_paddr[AW-1:0];
  assign req_d.wdata = i_pwdata;

  // Access cycle always follows setup, no wait states
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      acc_q <= 1'b0;
    end else begin
      acc_q <= setup;
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      req_q <= req_d;
    end
  end

  assign access = acc_q & i_psel & i_penable;

  assign o_pready  = access;
  assign o_pslverr = access & req_q.oor;

  // Write lands at the edge ending the access cycle
  assign o_wen   = access & req_q.write & ~req_q.oor;
  assign o_wa    = req_q.addr;
  assign o_wdata = req_q.wdata;

  // Read returns the word as it stands in the access cycle
  assign o_ra     = req_q.addr;
  assign o_prdata = (access & ~req_q.write & ~req_q.oor) ? i_rdata : '0;

endmodule : apb_rf_bridge

//--- verilog/rf_alu_lane.sv
// Two-stage ALU lane reading two register-file operands and writing one result, with forwarding
`timescale 1ns/1ps

module rf_alu_lane #(
  // Data width in bits
  parameter int W = 32
) (
  input  wire logic                       clk
, input  wire logic                       i_rst_n
  // Operation in, accepted on every valid cycle
, input  wire logic                       i_op_valid
, input  wire rf_pkg::rf_op_t             i_op
  // Source read ports
, output wire logic [rf_pkg::RF_AW-1:0]   o_rs1_a
, output wire logic [rf_pkg::RF_AW-1:0]   o_rs2_a
, input  wire logic [W-1:0]               i_rs1_d
, input  wire logic [W-1:0]               i_rs2_d
  // Result write port
, output wire logic                       o_wen
, output wire logic [rf_pkg::RF_AW-1:0]   o_wa
, output wire logic [W-1:0]               o_wdata
  // Result outputs
, output wire logic                       o_res_valid
, output wire logic [rf_pkg::RF_AW-1:0]   o_res_rd
, output wire logic [W-1:0]               o_res_data
);

  localparam int AW = rf_pkg::RF_AW;

  // Pending result in the writeback stage
  typedef struct packed {
    logic [AW-1:0] rd;
    logic [W-1:0]  data;
  } alu_res_t;

  alu_res_t     res_d;
  alu_res_t     res_q;
  logic         vld_q;
  logic         fwd_rs1;
  logic         fwd_rs2;
  logic [W-1:0] opa;
  logic [W-1:0] opb;

  // Sources read straight from the incoming op
  assign o_rs1_a = i_op.rs1;
  assign o_rs2_a = i_op.rs2;

  // Pending result is not in the file until the end of this cycle
  assign fwd_rs1 = vld_q & (res_q.rd == i_op.rs1);
  assign fwd_rs2 = vld_q & (res_q.rd == i_op.rs2);

  assign opa = fwd_rs1 ? res_q.data : i_rs1_d;
  assign opb = fwd_rs2 ? res_q.data : i_rs2_d;

  // Execute stage
  always_comb begin
    res_d.rd = i_op.rd;
    case (i_op.opc)
      rf_pkg::OPC_ADD: res_d.data = opa + opb;
      rf_pkg::OPC_SUB: res_d.data = opa - opb;
      rf_pkg::OPC_AND: res_d.data = opa & opb;
      rf_pkg::OPC_XOR: res_d.data = opa ^ opb;
      default:         res_d.data = '0;
    endcase
  end

  // Writeback stage valid
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= i_op_valid;
    end
  end

  // Writeback stage payload
  always_ff @(posedge clk) begin
    if (i_op_valid) begin
      res_q <= res_d;
    end
  end

  // Same stage register feeds the file and the result outputs
  assign o_wen   = vld_q;
  assign o_wa    = res_q.rd;
  assign o_wdata = res_q.data;

  assign o_res_valid = vld_q;
  assign o_res_rd    = res_q.rd;
  assign o_res_data  = res_q.data;

endmodule : rf_alu_lane

//--- verilog/rf_subsys_top.sv
// Register-file subsystem top joining the APB bridge, ALU lane and register file
`timescale 1ns/1ps

module rf_subsys_top #(
  // Data width in bits
  parameter int W = 32
) (
  input  wire logic                       clk
, input  wire logic                       i_rst_n
  // APB slave
, input  wire logic                       i_psel
, input  wire logic                       i_penable
, input  wire logic                       i_pwrite
, input  wire logic [rf_pkg::RF_AW+1:0]   i_paddr
, input  wire logic [W-1:0]               i_pwdata
, output wire logic [W-1:0]               o_prdata
, output wire logic                       o_pready
, output wire logic                       o_pslverr
  // ALU operations and results
, input  wire logic                       i_op_valid
, input  wire rf_pkg::rf_op_t             i_op
, output wire logic                       o_res_valid
, output wire logic [rf_pkg::RF_AW-1:0]   o_res_rd
, output wire logic [W-1:0]               o_res_data
);

  localparam int AW   = rf_pkg::RF_AW;
  // Bridge plus two lane sources
  localparam int RD_N = 3;
  // Bridge on port 0, lane on port 1 so the lane wins
  localparam int WR_N = 2;

  logic [RD_N-1:0][AW-1:0] rf_ra;
  logic [RD_N-1:0][W-1:0]  rf_rdata;
  logic [WR_N-1:0]         rf_wen;
  logic [WR_N-1:0][AW-1:0] rf_wa;
  logic [WR_N-1:0][W-1:0]  rf_wdata;

  apb_rf_bridge #(.W(W)) u_bridge (
    .clk       (clk)
  , .i_rst_n   (i_rst_n)
  , .i_psel    (i_psel)
  , .i_penable (i_penable)
  , .i_pwrite  (i_pwrite)
  , .i_paddr   (i_paddr)
  , .i_pwdata  (i_pwdata)
  , .o_prdata  (o_prdata)
  , .o_pready  (o_pready)
  , .o_pslverr (o_pslverr)
  , .o_ra      (rf_ra[0])
  , .i_rdata   (rf_rdata[0])
  , .o_wen     (rf_wen[0])
  , .o_wa      (rf_wa[0])
  , .o_wdata   (rf_wdata[0])
  );

  rf_alu_lane #(.W(W)) u_lane (
    .clk         (clk)
  , .i_rst_n     (i_rst_n)
  , .i_op_valid  (i_op_valid)
  , .i_op        (i_op)
  , .o_rs1_a     (rf_ra[1])
  , .o_rs2_a     (rf_ra[2])
  , .i_rs1_d     (rf_rdata[1])
  , .i_rs2_d     (rf_rdata[2])
  , .o_wen       (rf_wen[1])
  , .o_wa        (rf_wa[1])
  , .o_wdata     (rf_wdata[1])
  , .o_res_valid (o_res_valid)
  , .o_res_rd    (o_res_rd)
  , .o_res_data  (o_res_data)
  );

  rf #(.W(W), .RD_N(RD_N), .WR_N(WR_N)) u_rf (
    .clk     (clk)
  , .i_ra    (rf_ra)
  , .o_rdata (rf_rdata)
  , .i_wen   (rf_wen)
  , .i_wa    (rf_wa)
  , .i_wdata (rf_wdata)
  );

endmodule : rf_subsys_top
